// File: Bender.yml
package:
  name: lpc_levinson

sources:
  - files:
      - hdl/lpc_pkg.sv
      - hdl/div_if.sv
      - hdl/q_divider.sv
      - hdl/lpc_datapath.sv
      - hdl/ld_index_counter.sv
      - hdl/ld_control.sv
      - hdl/lpc_levinson.sv
  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/tb_levinson.sv

// File: compile.f
hdl/lpc_pkg.sv
hdl/div_if.sv
hdl/q_divider.sv
hdl/lpc_datapath.sv
hdl/ld_index_counter.sv
hdl/ld_control.sv
hdl/lpc_levinson.sv
testbench/tb_clock_gen.sv
testbench/tb_levinson.sv

// File: hdl/div_if.sv
interface div_if;
	import lpc_pkg::*;

	logic start;
	q_t num;
	q_t den;
	q_t quot;
	logic done;

	// control side starts a division and waits on done
	modport ctrl (output start, input done);

	// datapath supplies operands and picks up the quotient
	modport data (output num, output den, input quot);

	modport div (input start, input num, input den, output quot, output done);

endinterface

// File: hdl/ld_control.sv
module ld_control (
	input logic clk,
	input logic rst,
	input logic corr_req,
	input logic lpc_ack,
	input logic j_below_i,
	input logic j_last_word,
	input logic i_last,
	output logic corr_ack,
	output logic lpc_req,
	output lpc_pkg::op_t op,
	output logic i_clr,
	output logic i_inc,
	output logic j_clr,
	output logic j_inc,
	div_if.ctrl div
);
	import lpc_pkg::*;

	typedef enum logic [3:0] {
		S_IDLE,
		S_LD_REQ,
		S_LD_ACK,
		S_INIT,
		S_ITER,
		S_SUM,
		S_DIV_GO,
		S_DIV_WAIT,
		S_UPD_A,
		S_SET_AI,
		S_COMMIT,
		S_UPD_E,
		S_UL_REQ,
		S_UL_ACK
	} state_t;

	state_t state;
	state_t nxt_state;

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			state <= S_IDLE;
		else
			state <= nxt_state;
	end

	// handshake levels come straight from the state
	assign corr_ack = (state == S_LD_ACK);
	assign lpc_req = (state == S_UL_REQ);

	always_comb
	begin
		nxt_state = state;
		op = NOP;
		i_clr = 1'b0;
		i_inc = 1'b0;
		j_clr = 1'b0;
		j_inc = 1'b0;
		div.start = 1'b0;
		case (state)
			// i_clr together with j_clr puts j at zero
			S_IDLE:
			begin
				i_clr = 1'b1;
				j_clr = 1'b1;
				nxt_state = S_LD_REQ;
			end
			S_LD_REQ:
				if (corr_req)
				begin
					op = LOAD_R;
					nxt_state = S_LD_ACK;
				end
			S_LD_ACK:
				if (!corr_req)
				begin
					j_inc = !j_last_word;
					nxt_state = j_last_word ? S_INIT : S_LD_REQ;
				end
			S_INIT:
			begin
				op = INIT_E;
				nxt_state = S_ITER;
			end
			// ----------------------------------------
			// one iteration of the recursion
			// ----------------------------------------
			S_ITER:
			begin
				op = CLR_SUM;
				j_clr = 1'b1;
				nxt_state = S_SUM;
			end
			S_SUM:
				if (j_below_i)
				begin
					op = MAC_SUM;
					j_inc = 1'b1;
				end
				else
					nxt_state = S_DIV_GO;
			S_DIV_GO:
			begin
				div.start = 1'b1;
				nxt_state = S_DIV_WAIT;
			end
			S_DIV_WAIT:
				if (div.done)
				begin
					op = LATCH_K;
					j_clr = 1'b1;
					nxt_state = S_UPD_A;
				end
			S_UPD_A:
				if (j_below_i)
				begin
					op = UPDATE_A;
					j_inc = 1'b1;
				end
				else
					nxt_state = S_SET_AI;
			S_SET_AI:
			begin
				op = SET_AI;
				nxt_state = S_COMMIT;
			end
			S_COMMIT:
			begin
				op = COMMIT_A;
				nxt_state = S_UPD_E;
			end
			S_UPD_E:
			begin
				op = UPDATE_E;
				i_inc = !i_last;
				i_clr = i_last;
				j_clr = i_last;
				nxt_state = i_last ? S_UL_REQ : S_ITER;
			end
			// ----------------------------------------
			// unload a0..a10
			// ----------------------------------------
			S_UL_REQ:
				if (lpc_ack)
					nxt_state = S_UL_ACK;
			S_UL_ACK:
				if (!lpc_ack)
				begin
					j_inc = !j_last_word;
					nxt_state = j_last_word ? S_IDLE : S_UL_REQ;
				end
			default:
				nxt_state = S_IDLE;
		endcase
	end

endmodule

// File: hdl/ld_index_counter.sv
module ld_index_counter (
	input logic clk,
	input logic rst,
	input logic i_clr,
	input logic i_inc,
	input logic j_clr,
	input logic j_inc,
	output lpc_pkg::idx_t i,
	output lpc_pkg::idx_t j,
	output logic j_below_i,
	output logic j_last_word,
	output logic i_last
);
	import lpc_pkg::*;

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			i <= '0;
			j <= '0;
		end
		else
		begin
			if (i_clr)
				i <= idx_t'(1);
			else if (i_inc)
				i <= i + idx_t'(1);

			// word index for load and unload, element index for the inner loops
			if (j_clr)
				j <= i_clr ? idx_t'(0) : idx_t'(1);
			else if (j_inc)
				j <= j + idx_t'(1);
		end
	end

	assign j_below_i = (j < i);
	assign j_last_word = (j == idx_t'(ORDER));
	assign i_last = (i == idx_t'(ORDER));

endmodule

// File: hdl/lpc_datapath.sv
module lpc_datapath (
	input logic clk,
	input logic rst,
	input lpc_pkg::op_t op,
	input lpc_pkg::idx_t i,
	input lpc_pkg::idx_t j,
	input lpc_pkg::q_t corr_data,
	output lpc_pkg::q_t lpc_data,
	div_if.data div
);
	import lpc_pkg::*;

	q_t r [N_COEF];
	q_t a [N_COEF];
	q_t a_nxt [N_COEF];
	q_t sum;
	q_t k;
	q_t e;
	idx_t i_minus_j;
	q_t mul_a;
	q_t mul_b;
	logic signed [2*QW-1:0] prod;
	q_t mul_out;
	q_t add_a;
	q_t add_b;
	q_t add_out;
	q_t k_neg;
	q_t k_clamp;

	assign i_minus_j = i - j;

	// ----------------------------------------
	// shared multiplier and adder
	// ----------------------------------------
	always_comb
	begin
		mul_a = e;
		mul_b = sum;
		add_a = r[i];
		add_b = sum;
		case (op)
			MAC_SUM:
			begin
				mul_a = a[j];
				mul_b = r[i_minus_j];
				add_a = sum;
				add_b = mul_out;
			end
			UPDATE_A:
			begin
				mul_a = k;
				mul_b = a[i_minus_j];
				add_a = a[j];
				add_b = mul_out;
			end
			// one minus k squared, parked in sum for the error update
			COMMIT_A:
			begin
				mul_a = k;
				mul_b = k;
				add_a = ONE;
				add_b = -mul_out;
			end
			default:
			begin
			end
		endcase
	end

	assign prod = mul_a * mul_b;
	assign mul_out = prod[FRAC +: QW];
	assign add_out = add_a + add_b;

	// idle adder path gives R[i] plus the sum
	assign div.num = add_out;
	assign div.den = e;

	assign k_neg = -div.quot;
	assign k_clamp = (k_neg > ONE || k_neg < -ONE) ? '0 : k_neg;

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			sum <= '0;
			k <= '0;
			e <= '0;
		end
		else
			case (op)
				INIT_E: e <= r[0];
				CLR_SUM: sum <= '0;
				MAC_SUM, COMMIT_A: sum <= add_out;
				LATCH_K: k <= k_clamp;
				UPDATE_E: e <= mul_out;
				default: ;
			endcase
	end

	always_ff @(posedge clk)
	begin
		case (op)
			LOAD_R: r[j] <= corr_data;
			INIT_E:
				for (int n = 0; n < N_COEF; n++)
				begin
					a[n] <= '0;
					a_nxt[n] <= '0;
				end
			UPDATE_A: a_nxt[j] <= add_out;
			SET_AI: a_nxt[i] <= k;
			COMMIT_A: a <= a_nxt;
			default: ;
		endcase
	end

	// a0 is fixed at one
	assign lpc_data = (j == '0) ? ONE : a[j];

endmodule

// File: hdl/lpc_levinson.sv
module lpc_levinson (
	input logic clk,
	input logic rst,
	input logic corr_req,
	input lpc_pkg::q_t corr_data,
	output logic corr_ack,
	output logic lpc_req,
	output lpc_pkg::q_t lpc_data,
	input logic lpc_ack
);
	import lpc_pkg::*;

	op_t op;
	idx_t i;
	idx_t j;
	logic i_clr;
	logic i_inc;
	logic j_clr;
	logic j_inc;
	logic j_below_i;
	logic j_last_word;
	logic i_last;

	// one division at a time, shared by control, datapath and divider
	div_if div_bus ();

	ld_control u_control (
		.clk (clk),
		.rst (rst),
		.corr_req (corr_req),
		.lpc_ack (lpc_ack),
		.j_below_i (j_below_i),
		.j_last_word (j_last_word),
		.i_last (i_last),
		.corr_ack (corr_ack),
		.lpc_req (lpc_req),
		.op (op),
		.i_clr (i_clr),
		.i_inc (i_inc),
		.j_clr (j_clr),
		.j_inc (j_inc),
		.div (div_bus)
	);

	ld_index_counter u_index (
		.clk (clk),
		.rst (rst),
		.i_clr (i_clr),
		.i_inc (i_inc),
		.j_clr (j_clr),
		.j_inc (j_inc),
		.i (i),
		.j (j),
		.j_below_i (j_below_i),
		.j_last_word (j_last_word),
		.i_last (i_last)
	);

	lpc_datapath u_datapath (
		.clk (clk),
		.rst (rst),
		.op (op),
		.i (i),
		.j (j),
		.corr_data (corr_data),
		.lpc_data (lpc_data),
		.div (div_bus)
	);

	q_divider u_divider (
		.clk (clk),
		.rst (rst),
		.div (div_bus)
	);

endmodule

// File: hdl/lpc_pkg.sv
package lpc_pkg;

	// ----------------------------------------
	// word format and sizes
	// ----------------------------------------
	localparam int QW = 32;
	localparam int FRAC = 16;
	localparam int ORDER = 10;
	localparam int N_COEF = ORDER + 1;

	// restoring divider runs one step per quotient bit
	localparam int DIV_STEPS = QW + FRAC;

	// two's complement, FRAC fraction bits
	typedef logic signed [QW-1:0] q_t;

	// covers 0..ORDER for both i and j
	typedef logic [3:0] idx_t;

	localparam q_t ONE = q_t'(1 << FRAC);

	// ----------------------------------------
	// datapath operations, one per cycle
	// ----------------------------------------
	typedef enum logic [3:0] {
		NOP,
		LOAD_R,
		INIT_E,
		CLR_SUM,
		MAC_SUM,
		LATCH_K,
		UPDATE_A,
		SET_AI,
		COMMIT_A,
		UPDATE_E
	} op_t;

endpackage

// File: hdl/q_divider.sv
module q_divider (
	input logic clk,
	input logic rst,
	div_if.div div
);
	import lpc_pkg::*;

	logic busy;
	logic [$clog2(DIV_STEPS)-1:0] step;
	logic [QW-1:0] num_mag;
	logic [QW-1:0] den_mag;
	logic [QW-1:0] dvs;
	logic [QW-1:0] rem;
	logic [DIV_STEPS-1:0] dvd;
	logic neg;
	logic den_zero;
	logic [QW:0] rem_sh;
	logic [QW:0] rem_diff;
	logic ge;
	logic [DIV_STEPS-1:0] dvd_nxt;
	logic [QW-1:0] q_mag;

	assign num_mag = div.num[QW-1] ? -div.num : div.num;
	assign den_mag = div.den[QW-1] ? -div.den : div.den;

	// ----------------------------------------
	// one restoring step per cycle
	// ----------------------------------------
	assign rem_sh = {rem, dvd[DIV_STEPS-1]};
	assign rem_diff = rem_sh - {1'b0, dvs};
	assign ge = (rem_sh >= {1'b0, dvs});
	// quotient bits shift in from the bottom as the dividend leaves the top
	assign dvd_nxt = {dvd[DIV_STEPS-2:0], ge};
	assign q_mag = dvd_nxt[QW-1:0];

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			busy <= 1'b0;
			step <= '0;
			div.done <= 1'b0;
		end
		else
		begin
			div.done <= 1'b0;
			if (div.start)
			begin
				busy <= 1'b1;
				step <= '0;
			end
			else if (busy)
			begin
				step <= step + 1'b1;
				if (step == DIV_STEPS - 1)
				begin
					busy <= 1'b0;
					div.done <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (div.start)
		begin
			dvs <= den_mag;
			rem <= '0;
			dvd <= {num_mag, {FRAC{1'b0}}};
			neg <= div.num[QW-1] ^ div.den[QW-1];
			den_zero <= (div.den == '0);
		end
		else if (busy)
		begin
			rem <= ge ? rem_diff[QW-1:0] : rem_sh[QW-1:0];
			dvd <= dvd_nxt;
			// sign goes on after the last step, zero divisor forces zero
			if (step == DIV_STEPS - 1)
				div.quot <= den_zero ? '0 : (neg ? -q_mag : q_mag);
		end
	end

endmodule

// File: testbench/tb_clock_gen.sv
module tb_clock_gen #(
	parameter int PERIOD = 100
) (
	output logic clk
);

	initial
	begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

endmodule

// File: testbench/tb_levinson.sv
module tb_levinson;
	import lpc_pkg::*;

	typedef q_t frame_t [N_COEF];

	// 1 + 8 + 1 + 2 + 4 frames over all tests
	localparam int N_FRAMES = 16;
	localparam int TIMEOUT = 2500 * N_FRAMES;

	logic clk;
	logic rst;
	logic corr_req;
	q_t corr_data;
	logic corr_ack;
	logic lpc_req;
	q_t lpc_data;
	logic lpc_ack;

	frame_t stim;
	frame_t got;
	frame_t expected;
	frame_t earlier;
	logic [31:0] rng;
	int cycles = 0;
	int checks = 0;
	int errors = 0;

	tb_clock_gen #(.PERIOD(100)) u_clock (.clk(clk));

	lpc_levinson UUT (
		.clk (clk),
		.rst (rst),
		.corr_req (corr_req),
		.corr_data (corr_data),
		.corr_ack (corr_ack),
		.lpc_req (lpc_req),
		.lpc_data (lpc_data),
		.lpc_ack (lpc_ack)
	);

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT)
		begin
			$display("timeout after %0d cycles, the DUT stopped answering", cycles);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	// ----------------------------------------
	// reference arithmetic
	// ----------------------------------------
	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic q_t product(input q_t x, input q_t y);
		longint px;
		longint py;
		logic [63:0] p;
		px = x;
		py = y;
		p = px * py;
		return p[FRAC +: QW];
	endfunction

	function automatic q_t quotient(input q_t num, input q_t den);
		logic [QW-1:0] num_mag;
		logic [QW-1:0] den_mag;
		logic [DIV_STEPS-1:0] q;
		if (den == '0)
			return '0;
		num_mag = num[QW-1] ? -num : num;
		den_mag = den[QW-1] ? -den : den;
		q = {num_mag, {FRAC{1'b0}}} / den_mag;
		// only the low word survives
		return (num[QW-1] ^ den[QW-1]) ? -q[QW-1:0] : q[QW-1:0];
	endfunction

	// order-10 recursion on stim, result in expected
	function automatic void levinson_model();
		q_t a [N_COEF];
		q_t nxt [N_COEF];
		q_t sum;
		q_t k;
		q_t e;
		e = stim[0];
		for (int n = 0; n < N_COEF; n++)
			a[n] = '0;
		for (int i = 1; i <= ORDER; i++)
		begin
			sum = '0;
			for (int j = 1; j < i; j++)
				sum = sum + product(a[j], stim[i-j]);
			k = -quotient(stim[i] + sum, e);
			if (k > ONE || k < -ONE)
				k = '0;
			nxt = a;
			for (int j = 1; j < i; j++)
				nxt[j] = a[j] + product(k, a[i-j]);
			nxt[i] = k;
			a = nxt;
			e = product(e, ONE - product(k, k));
		end
		expected = a;
		expected[0] = ONE;
	endfunction

	// ----------------------------------------
	// stimulus and checks
	// ----------------------------------------
	task automatic compare_word(input string name, input q_t value, input q_t want);
		checks++;
		assert (value === want)
		else
		begin
			$display("Fail %s: got %h expected %h", name, value, want);
			errors++;
		end
	endtask

	task automatic apply_reset();
		@(posedge clk);
		rst <= 1'b0;
		repeat (5) @(posedge clk);
		rst <= 1'b1;
	endtask

	task automatic random_pause();
		rng = xorshift(rng);
		repeat (rng[2:0]) @(posedge clk);
	endtask

	// R0 between 1 and 256, the others smaller in magnitude
	task automatic random_frame();
		logic [31:0] mag;
		rng = xorshift(rng);
		stim[0] = q_t'(32'h0001_0000 + rng % 32'h00ff_0000);
		for (int n = 1; n < N_COEF; n++)
		begin
			rng = xorshift(rng);
			mag = rng % stim[0];
			rng = xorshift(rng);
			stim[n] = rng[0] ? -q_t'(mag) : q_t'(mag);
		end
	endtask

	task automatic run_frame(input bit delays);
		for (int n = 0; n < N_COEF; n++)
		begin
			if (delays)
				random_pause();
			@(posedge clk);
			corr_req <= 1'b1;
			corr_data <= stim[n];
			do @(negedge clk); while (!corr_ack);
			@(posedge clk);
			corr_req <= 1'b0;
			do @(negedge clk); while (corr_ack);
		end
		for (int n = 0; n < N_COEF; n++)
		begin
			do @(negedge clk); while (!lpc_req);
			got[n] = lpc_data;
			if (delays)
				random_pause();
			@(posedge clk);
			lpc_ack <= 1'b1;
			do @(negedge clk); while (lpc_req);
			@(posedge clk);
			lpc_ack <= 1'b0;
		end
	endtask

	task automatic check_frame();
		levinson_model();
		for (int n = 0; n < N_COEF; n++)
			compare_word($sformatf("lpc_data a%0d", n), got[n], expected[n]);
	endtask

	task automatic compare_earlier();
		for (int n = 0; n < N_COEF; n++)
			compare_word($sformatf("lpc_data a%0d rerun", n), got[n], earlier[n]);
	endtask

	// ----------------------------------------
	// directed tests
	// ----------------------------------------
	task automatic reset_values();
		@(negedge clk);
		compare_word("corr_ack", q_t'(corr_ack), '0);
		compare_word("lpc_req", q_t'(lpc_req), '0);
	endtask

	task automatic half_frame();
		for (int n = 0; n < N_COEF; n++)
			stim[n] = '0;
		stim[0] = ONE;
		stim[1] = ONE >>> 1;
		run_frame(1'b0);
		check_frame();
	endtask

	task automatic random_frames();
		repeat (8)
		begin
			random_frame();
			run_frame(1'b0);
			check_frame();
		end
	endtask

	// first reflection coefficient is -2 and must be cleared
	task automatic clamp_frame();
		for (int n = 0; n < N_COEF; n++)
			stim[n] = '0;
		stim[0] = ONE;
		stim[1] = ONE <<< 1;
		run_frame(1'b0);
		check_frame();
		compare_word("lpc_data a1 clamped", got[1], '0);
	endtask

	task automatic back_pressure();
		random_frame();
		run_frame(1'b0);
		earlier = got;
		run_frame(1'b1);
		compare_earlier();
		check_frame();
	endtask

	task automatic back_to_back();
		frame_t frame_a;
		frame_t frame_b;
		frame_t out_a;
		frame_t out_b;
		random_frame();
		frame_a = stim;
		random_frame();
		frame_b = stim;
		apply_reset();
		stim = frame_a;
		run_frame(1'b0);
		out_a = got;
		apply_reset();
		stim = frame_b;
		run_frame(1'b0);
		out_b = got;
		// no reset between these two
		stim = frame_a;
		run_frame(1'b0);
		earlier = out_a;
		compare_earlier();
		check_frame();
		stim = frame_b;
		run_frame(1'b0);
		earlier = out_b;
		compare_earlier();
		check_frame();
	endtask

	initial
	begin
		rst = 1'b0;
		corr_req = 1'b0;
		corr_data = '0;
		lpc_ack = 1'b0;
		rng = 32'h07905b9f;
		apply_reset();
		reset_values();
		half_frame();
		random_frames();
		clamp_frame();
		back_pressure();
		back_to_back();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule
